//--- design/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor #(
    parameter int BP_ENTRIES = 16
) (
    input  logic             clk,
    input  logic             rst,

    input  fetch_pkg::addr_t cur_pc,
    output fetch_pkg::addr_t next_pc,

    input  logic             update_valid,
    input  fetch_pkg::addr_t update_pc,
    input  logic             update_taken,
    input  fetch_pkg::addr_t update_target
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BP_ENTRIES);
    localparam int TAG_W = 32 - IDX_W - 2;

    // entry storage
    logic [BP_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]      tag_tbl    [BP_ENTRIES];
    addr_t                 target_tbl [BP_ENTRIES];
    ctr_t                  ctr_tbl    [BP_ENTRIES];

    logic [IDX_W-1:0]      rd_idx;
    logic [TAG_W-1:0]      rd_tag;
    logic [IDX_W-1:0]      wr_idx;
    logic [TAG_W-1:0]      wr_tag;
    logic                  hit;
    logic                  same_entry;
    ctr_t                  ctr_base;

    // one saturating step toward the resolved direction
    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        ctr_t r;
        r = c;
        if (taken && c != ctr_strong_t) begin
            r = c + 2'd1;
        end else if (!taken && c != ctr_strong_nt) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    // lookup, word index below and tag above
    assign rd_idx = cur_pc[IDX_W+1:2];
    assign rd_tag = cur_pc[31:IDX_W+2];
    assign hit    = valid[rd_idx] && (tag_tbl[rd_idx] == rd_tag);

    assign next_pc = (hit && ctr_tbl[rd_idx] >= ctr_weak_t) ? target_tbl[rd_idx]
                                                           : cur_pc + 32'd4;

    // training
    assign wr_idx     = update_pc[IDX_W+1:2];
    assign wr_tag     = update_pc[31:IDX_W+2];
    assign same_entry = valid[wr_idx] && (tag_tbl[wr_idx] == wr_tag);

    // a new branch takes over the slot from the reset counter value
    assign ctr_base = same_entry ? ctr_tbl[wr_idx] : ctr_reset;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (update_valid) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            tag_tbl[wr_idx]    <= wr_tag;
            target_tbl[wr_idx] <= update_target;
            ctr_tbl[wr_idx]    <= ctr_step(ctr_base, update_taken);
        end
    end

    // execute stage only resolves whole instructions
    assert property (@(posedge clk) disable iff (rst)
        update_valid |-> update_pc[1:0] == 2'b00)
        else $error("branch_predictor: update_pc not word aligned");

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    // byte address of a 32-bit instruction
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // first fetch address out of reset
    localparam addr_t reset_pc = 32'h0000_0000;

    // two-bit saturating branch counter
    typedef logic [1:0] ctr_t;

    // counter encoding, upper half predicts taken
    localparam ctr_t ctr_strong_nt = 2'd0;
    localparam ctr_t ctr_weak_nt   = 2'd1;
    localparam ctr_t ctr_weak_t    = 2'd2;
    localparam ctr_t ctr_strong_t  = 2'd3;

    // fresh entries start weakly not taken
    localparam ctr_t ctr_reset = ctr_weak_nt;

endpackage

//--- design/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter int QUEUE_DEPTH = 16,
    parameter int BP_ENTRIES  = 16,
    parameter int MEM_WORDS   = 64,
    parameter int MEM_LATENCY = 2
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    output logic             fetch_valid,
    input  logic             fetch_ready,
    output fetch_pkg::addr_t fetch_pc,
    output fetch_pkg::inst_t fetch_inst,

    input  logic             update_valid,
    input  fetch_pkg::addr_t update_pc,
    input  logic             update_taken,
    input  fetch_pkg::addr_t update_target
);

    import fetch_pkg::*;

    // queue to memory
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_pc;
    logic  mem_resp_valid;
    addr_t mem_resp_pc;
    inst_t mem_resp_inst;

    // queue to predictor
    addr_t cur_pc;
    addr_t next_pc;

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) inst_queue_inst (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_pc     (mem_req_pc),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_pc    (mem_resp_pc),
        .mem_resp_inst  (mem_resp_inst),
        .cur_pc         (cur_pc),
        .next_pc        (next_pc)
    );

    branch_predictor #(
        .BP_ENTRIES(BP_ENTRIES)
    ) branch_predictor_inst (
        .clk           (clk),
        .rst           (rst),
        .cur_pc        (cur_pc),
        .next_pc       (next_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    inst_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) inst_mem_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_pc     (mem_req_pc),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_pc    (mem_resp_pc),
        .mem_resp_inst  (mem_resp_inst)
    );

endmodule

//--- design/inst_mem.sv
`timescale 1ns/100ps

module inst_mem #(
    parameter int MEM_WORDS   = 64,
    parameter int MEM_LATENCY = 2
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             mem_req_valid,
    output logic             mem_req_ready,
    input  fetch_pkg::addr_t mem_req_pc,

    output logic             mem_resp_valid,
    output fetch_pkg::addr_t mem_resp_pc,
    output fetch_pkg::inst_t mem_resp_inst
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    inst_t             rom [MEM_WORDS];

    // cycles left until the pending response
    logic [CNT_W-1:0]  cnt;
    addr_t             hold_pc;
    logic [IDX_W-1:0]  rd_idx;
    logic              accept;

    initial begin
        $readmemh("program.hex", rom);
    end

    // free again in the response cycle so requests can run back to back
    assign mem_req_ready = (cnt == CNT_W'(0)) || (cnt == CNT_W'(1));
    assign accept        = mem_req_valid && mem_req_ready;

    assign mem_resp_valid = (cnt == CNT_W'(1));
    assign mem_resp_pc    = hold_pc;

    // out of range addresses wrap around the rom
    assign rd_idx        = IDX_W'(hold_pc[31:2] % 30'(MEM_WORDS));
    assign mem_resp_inst = rom[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= CNT_W'(MEM_LATENCY);
        end else if (cnt != CNT_W'(0)) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_pc <= mem_req_pc;
        end
    end

    // no second request while the first is still in flight
    if (MEM_LATENCY > 1) begin : g_busy_check
        assert property (@(posedge clk) disable iff (rst)
            accept |-> ##1 (!accept) [*MEM_LATENCY-1])
            else $error("inst_mem: request accepted while busy");
    end

endmodule

//--- design/inst_queue.sv
`timescale 1ns/100ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    output logic             fetch_valid,
    input  logic             fetch_ready,
    output fetch_pkg::addr_t fetch_pc,
    output fetch_pkg::inst_t fetch_inst,

    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output fetch_pkg::addr_t mem_req_pc,

    input  logic             mem_resp_valid,
    input  fetch_pkg::addr_t mem_resp_pc,
    input  fetch_pkg::inst_t mem_resp_inst,

    output fetch_pkg::addr_t cur_pc,
    input  fetch_pkg::addr_t next_pc
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // circular buffer
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    addr_t            pc_q   [QUEUE_DEPTH];
    inst_t            inst_q [QUEUE_DEPTH];

    // fetch sequencer state
    addr_t            pc;
    logic             requested;
    addr_t            request_pc;

    logic             queue_empty;
    logic             queue_full;
    logic             mispredict;
    logic             resp_match;
    logic             req_fire;
    logic             enq;
    logic             deq;

    assign queue_empty = (head == tail);

    // a redirect that matches the pending fetch on an empty queue is just a slow fetch
    assign mispredict = redirect_valid &&
                        (!requested || (request_pc != redirect_pc) || !queue_empty);

    // stale words from before a flush fall through here
    assign resp_match = requested && mem_resp_valid && (mem_resp_pc == request_pc);

    // full one slot early, so the word in flight always has room
    // and the check never has to look at the response
    assign queue_full = (tail + PTR_W'(1) == head) || (tail + PTR_W'(2) == head);

    // one request outstanding, the next one leaves as the current one returns
    assign mem_req_valid = mispredict || (!queue_full && (!requested || resp_match));
    assign mem_req_pc    = mispredict ? redirect_pc : pc;
    assign req_fire      = mem_req_valid && mem_req_ready;

    // predictor looks at the address being issued
    assign cur_pc = mem_req_pc;

    assign enq = resp_match && !mispredict;

    // empty queue passes a matching response straight through
    assign fetch_valid = !redirect_valid && (!queue_empty || resp_match);
    assign fetch_pc    = queue_empty ? mem_resp_pc : pc_q[head];
    assign fetch_inst  = queue_empty ? mem_resp_inst : inst_q[head];
    assign deq         = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            pc        <= reset_pc;
            requested <= 1'b0;
        end else begin
            // pointers
            if (mispredict) begin
                head <= tail;
            end else begin
                if (enq) begin
                    tail <= tail + 1'b1;
                end
                if (deq) begin
                    head <= head + 1'b1;
                end
            end

            // request tracking
            if (req_fire) begin
                requested <= 1'b1;
                pc        <= next_pc;
            end else if (mispredict) begin
                // memory busy, retry the redirect target later
                requested <= 1'b0;
                pc        <= redirect_pc;
            end else if (resp_match) begin
                requested <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            request_pc <= mem_req_pc;
        end
        if (enq) begin
            pc_q[tail]   <= mem_resp_pc;
            inst_q[tail] <= mem_resp_inst;
        end
    end

    // memory returns only the request that is outstanding here
    assert property (@(posedge clk) disable iff (rst)
        requested && mem_resp_valid |-> mem_resp_pc == request_pc)
        else $error("inst_queue: response does not belong to the outstanding request");

    // tail must never wrap onto head
    assert property (@(posedge clk) disable iff (rst)
        enq && !deq |=> !queue_empty)
        else $error("inst_queue: tail overran head");

endmodule

//--- fetch_unit.f
design/fetch_pkg.sv
design/inst_queue.sv
design/branch_predictor.sv
design/inst_mem.sv
design/fetch_unit.sv
test/fetch_unit_tb.sv

//--- program.hex
// one 32-bit instruction word per line, word address 0 upward
00100093
00200113
00308193
00410213
00518293
00620313
00728393
00830413
00938493
00a40513
00b48593
00c50613
00d58693
00e60713
00f68793
01070813
01178893
01280913
01388993
01490a13
01598a93
016a0b13
017a8b93
018b0c13
019b8c93
01ac0d13
01bc8d93
01cd0e13
01dd8e93
01ee0f13
01fe8f93
0000006f

//--- run.sh
#!/bin/sh
# build the fetch unit regression with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
    -f fetch_unit.f --top-module fetch_unit_tb -o fetch_unit_sim \
    && ./obj_dir/fetch_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/fetch_unit_tb.sv
`timescale 1ns/100ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int QUEUE_DEPTH = 16;
    localparam int BP_ENTRIES  = 16;
    localparam int MEM_WORDS   = 32;
    localparam int MEM_LATENCY = 2;
    localparam int TAG_SHIFT   = $clog2(BP_ENTRIES) + 2;
    localparam int N_ROWS      = 5;

    logic  clk;
    logic  rst;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  fetch_valid;
    logic  fetch_ready;
    addr_t fetch_pc;
    inst_t fetch_inst;
    logic  update_valid;
    addr_t update_pc;
    logic  update_taken;
    addr_t update_target;

    // stimulus table, one column per array
    string name_tbl [N_ROWS] = '{"reset_stream", "redirect_flush", "stall_random",
                                 "taken_branch", "not_taken_branch"};
    logic  redir_tbl      [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
    addr_t redir_pc_tbl   [N_ROWS] = '{32'h0, 32'h40, 32'h0, 32'h08, 32'h10};
    int    upd_cnt_tbl    [N_ROWS] = '{0, 0, 0, 2, 2};
    addr_t upd_pc_tbl     [N_ROWS] = '{32'h0, 32'h0, 32'h0, 32'h18, 32'h18};
    logic  upd_taken_tbl  [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    addr_t upd_target_tbl [N_ROWS] = '{32'h0, 32'h0, 32'h0, 32'h50, 32'h50};
    int    stall_tbl      [N_ROWS] = '{0, 0, 40, 0, 0};
    int    collect_tbl    [N_ROWS] = '{12, 8, 40, 10, 8};

    // reference model state
    inst_t  rom_model [MEM_WORDS];
    logic   bp_valid  [BP_ENTRIES];
    addr_t  bp_tag    [BP_ENTRIES];
    addr_t  bp_target [BP_ENTRIES];
    int     bp_ctr    [BP_ENTRIES];
    addr_t  exp_pc;
    integer seed = 32'hc96d0e3e;
    int     err_count = 0;

    fetch_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .BP_ENTRIES  (BP_ENTRIES),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) fetch_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        err_count++;
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // predicted successor, taken only on a hit with counter 2 or 3
    function automatic addr_t model_next(input addr_t pc);
        int idx;
        idx = int'((pc >> 2) % BP_ENTRIES);
        if (bp_valid[idx] && bp_tag[idx] == (pc >> TAG_SHIFT) && bp_ctr[idx] >= 2) begin
            return bp_target[idx];
        end
        return pc + 32'd4;
    endfunction

    task automatic model_train(input addr_t pc, input logic taken, input addr_t target);
        int idx;
        idx = int'((pc >> 2) % BP_ENTRIES);
        // a new branch in the slot starts weakly not taken
        if (!bp_valid[idx] || bp_tag[idx] != (pc >> TAG_SHIFT)) begin
            bp_ctr[idx] = 1;
        end
        if (taken && bp_ctr[idx] < 3) begin
            bp_ctr[idx]++;
        end else if (!taken && bp_ctr[idx] > 0) begin
            bp_ctr[idx]--;
        end
        bp_valid[idx]  = 1'b1;
        bp_tag[idx]    = pc >> TAG_SHIFT;
        bp_target[idx] = target;
    endtask

    task automatic run_row(input int r);
        int          got;
        int          cyc;
        logic [31:0] rnd;
        inst_t       exp_inst;
        got = 0;
        cyc = 0;
        for (int k = 0; k < upd_cnt_tbl[r]; k++) begin
            @(posedge clk);
            update_valid  <= 1'b1;
            update_pc     <= upd_pc_tbl[r];
            update_taken  <= upd_taken_tbl[r];
            update_target <= upd_target_tbl[r];
            model_train(upd_pc_tbl[r], upd_taken_tbl[r], upd_target_tbl[r]);
        end
        @(posedge clk);
        update_valid <= 1'b0;
        if (redir_tbl[r]) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= redir_pc_tbl[r];
            @(posedge clk);
            redirect_valid <= 1'b0;
            exp_pc = redir_pc_tbl[r];
        end
        while (got < collect_tbl[r]) begin
            @(posedge clk);
            if (cyc < stall_tbl[r]) begin
                fetch_ready <= 1'b0;
            end else begin
                rnd = $random(seed);
                fetch_ready <= rnd[0];
            end
            cyc++;
            // transfer is decided by the values settled before the next edge
            @(negedge clk);
            if (fetch_valid && fetch_ready) begin
                exp_inst = rom_model[(exp_pc >> 2) % MEM_WORDS];
                assert (fetch_pc == exp_pc)
                    else fail_run($sformatf("mismatch %s fetch_pc expected %h actual %h",
                                            name_tbl[r], exp_pc, fetch_pc));
                assert (fetch_inst == exp_inst)
                    else fail_run($sformatf("mismatch %s fetch_inst expected %h actual %h",
                                            name_tbl[r], exp_inst, fetch_inst));
                exp_pc = model_next(exp_pc);
                got++;
            end
        end
        @(posedge clk);
        fetch_ready <= 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fetch_ready    = 1'b0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_taken   = 1'b0;
        update_target  = '0;
        $readmemh("program.hex", rom_model);
        for (int i = 0; i < BP_ENTRIES; i++) begin
            bp_valid[i] = 1'b0;
            bp_ctr[i]   = 0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        exp_pc = reset_pc;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int limit;
        int max_stall;
        limit     = 0;
        max_stall = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            if (stall_tbl[r] > max_stall) begin
                max_stall = stall_tbl[r];
            end
        end
        for (int r = 0; r < N_ROWS; r++) begin
            limit += collect_tbl[r] * (MEM_LATENCY + max_stall + 8);
        end
        repeat (16 + limit) @(posedge clk);
        fail_run("timeout: the fetch stream did not deliver all expected instructions in time");
    end

endmodule
